// ==== all.f ====
dcache_pkg.sv
dcache_ctrl.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_mem_port.sv
dcache_top.sv
tb_dcache.sv

// ==== Makefile ====
SRCS = dcache_pkg.sv dcache_ctrl.sv dcache_tag_store.sv dcache_data_store.sv \
       dcache_mem_port.sv dcache_top.sv tb_dcache.sv

obj_dir/Vtb_dcache: all.f $(SRCS)
	verilator --binary -j 0 --top-module tb_dcache -f all.f -o Vtb_dcache

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb_dcache.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    logic clk = 1'b0;
    logic reset;
    addr_t addr;
    word_t wdata;
    size_t wlen;
    logic wrn;
    logic dcache_enable;
    word_t rdata;
    logic dcache_valid;
    logic write_done;
    addr_t awaddr;
    logic awvalid;
    logic awready;
    word_t wdata_m;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    addr_t araddr;
    logic arvalid;
    logic arready;
    word_t rdata_m;
    logic rlast;
    logic rvalid;
    logic rready;

    logic [7:0] backing [4096];     // slave memory
    logic [7:0] model [4096];       // intended memory contents
    tag_t m_tag [SETS];             // reference cache state
    logic m_valid [SETS];
    logic m_dirty [SETS];

    logic [31:0] lfsr = 32'he03d_5dd2;
    int errors = 0;
    int aw_cnt = 0;                 // ready delay counters
    int w_cnt = 0;
    int ar_cnt = 0;
    int b_cnt = 0;
    int r_cnt = 0;
    int wb_beat = 0;
    int r_beat = 0;
    int wb_count = 0;
    int ar_count = 0;
    logic b_pending = 1'b0;
    logic r_active = 1'b0;
    logic aw_hold = 1'b0;
    logic ar_hold = 1'b0;
    logic w_hold = 1'b0;
    addr_t aw_held;
    addr_t ar_held;
    addr_t wb_base;
    addr_t r_base;
    addr_t exp_awaddr;
    addr_t exp_araddr;

    dcache_top i_dut (.*);

    always #5 clk = ~clk;

    function automatic int rand_bits(input int n);
        int v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic word_t model_word(input logic [11:0] a);
        word_t w;
        for (int b = 0; b < 8; b++) w[8*b +: 8] = model[{a[11:3], 3'b000} + 12'(b)];
        return w;
    endfunction

    function automatic word_t backing_word(input logic [11:0] a);
        word_t w;
        for (int b = 0; b < 8; b++) w[8*b +: 8] = backing[{a[11:3], 3'b000} + 12'(b)];
        return w;
    endfunction

    task automatic check_eq(input string name, input word_t exp, input word_t got);
        assert (exp === got) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("%0d errors counted", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // memory slave with random ready delays
    always @(posedge clk) begin
        if (!reset) begin
            if (aw_hold) check_eq("awaddr", word_t'(aw_held), word_t'(awaddr));
            if (aw_hold) check_eq("awvalid", 64'd1, word_t'(awvalid));
            if (ar_hold) check_eq("araddr", word_t'(ar_held), word_t'(araddr));
            if (ar_hold) check_eq("arvalid", 64'd1, word_t'(arvalid));
            if (w_hold) check_eq("wvalid", 64'd1, word_t'(wvalid));
            aw_hold = awvalid && !awready;
            ar_hold = arvalid && !arready;
            w_hold = wvalid && !wready;
            aw_held = awaddr;
            ar_held = araddr;
            if (awvalid && awready) begin
                check_eq("awaddr", word_t'(exp_awaddr), word_t'(awaddr));
                wb_base = awaddr;
                wb_beat = 0;
                aw_cnt = rand_bits(2);
            end else if (awvalid && aw_cnt != 0) aw_cnt--;
            if (wvalid && wready) begin
                for (int b = 0; b < 8; b++)
                    backing[wb_base[11:0] + 12'(8 * wb_beat + b)] = wdata_m[8*b +: 8];
                check_eq("wlast", word_t'(wb_beat == 7), word_t'(wlast));
                if (wlast) begin
                    b_pending = 1'b1;
                    b_cnt = rand_bits(2);
                end
                wb_beat++;
                wb_count++;
                w_cnt = rand_bits(2);
            end else if (wvalid && w_cnt != 0) w_cnt--;
            if (bvalid) begin
                check_eq("bready", 64'd1, word_t'(bready));
                b_pending = 1'b0;
            end else if (b_pending && b_cnt != 0) b_cnt--;
            if (arvalid && arready) begin
                check_eq("araddr", word_t'(exp_araddr), word_t'(araddr));
                ar_count++;
                r_base = araddr;
                r_beat = 0;
                r_active = 1'b1;
                r_cnt = rand_bits(2);
                ar_cnt = rand_bits(2);
            end else if (arvalid && ar_cnt != 0) ar_cnt--;
            if (rvalid && rready) begin
                r_beat++;
                r_cnt = rand_bits(2);
                if (r_beat == 8) r_active = 1'b0;
            end else if (r_active && r_cnt != 0) r_cnt--;
        end
        #1;
        awready = (aw_cnt == 0);
        wready = (w_cnt == 0);
        arready = (ar_cnt == 0);
        bvalid = b_pending && (b_cnt == 0);
        rvalid = r_active && (r_cnt == 0);
        rlast = (r_beat == 7);
        // wrapped beat order from the critical word
        rdata_m = backing_word({r_base[11:6], 3'(r_base[5:3] + 3'(r_beat)), 3'b000});
    end

    task automatic access(input addr_t a, input logic wr, input size_t s, input word_t d,
                          output logic miss);
        set_idx_t set;
        tag_t tag;
        int exp_wb;
        int n;
        logic done;
        addr_t vbase;
        set = a[9:6];
        tag = a[31:10];
        miss = !(m_valid[set] && m_tag[set] == tag);
        exp_wb = (miss && m_valid[set] && m_dirty[set]) ? 8 : 0;
        vbase = {m_tag[set], set, 6'b000000};
        exp_awaddr = vbase;
        exp_araddr = {a[31:3], 3'b000};
        ar_count = 0;
        wb_count = 0;
        addr = a;
        wrn = wr;
        wlen = s;
        wdata = d;
        dcache_enable = 1'b1;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = wr ? write_done : dcache_valid;
            n++;
            if (!done && n >= 200) begin
                errors++;
                $display("timeout: access to %h never completed", a);
                finish_run();
            end
        end
        if (!wr) check_eq("rdata", model_word(a[11:0]), rdata);
        #1;
        dcache_enable = 1'b0;
        check_eq("ar_count", word_t'(miss), word_t'(ar_count));
        check_eq("wb_count", word_t'(exp_wb), word_t'(wb_count));
        if (exp_wb != 0) begin
            for (int w = 0; w < 8; w++)
                check_eq("victim line", model_word(vbase[11:0] + 12'(8 * w)),
                         backing_word(vbase[11:0] + 12'(8 * w)));
        end
        if (wr) begin
            for (int b = 0; b < (1 << s); b++) model[a[11:0] + 12'(b)] = d[8*b +: 8];
        end
        m_dirty[set] = miss ? wr : (m_dirty[set] | wr);
        m_valid[set] = 1'b1;
        m_tag[set] = tag;
    endtask

    initial begin
        addr_t a;
        size_t s;
        logic wr;
        logic miss;
        logic dummy;
        reset = 1'b1;
        addr = '0;
        wdata = '0;
        wlen = '0;
        wrn = 1'b0;
        dcache_enable = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        arready = 1'b0;
        rdata_m = '0;
        rlast = 1'b0;
        rvalid = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            backing[i] = 8'((i * 29) ^ (i >> 5));   // address-dependent fill pattern
            model[i] = backing[i];
        end
        for (int i = 0; i < SETS; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_tag[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        check_eq("reset outputs", 64'd0,
                 word_t'({awvalid, wvalid, arvalid, rready, dcache_valid, write_done}));
        #1;
        for (int i = 0; i < 300; i++) begin
            s = size_t'(rand_bits(2));
            a = addr_t'((rand_bits(2) % 3) * 1024 + rand_bits(10));   // three tags only
            a = a & ~addr_t'((1 << s) - 1);
            wr = (rand_bits(1) == 1);
            access(a, wr, s, word_t'({rand_bits(32), rand_bits(32)}), miss);
            if (wr) begin
                access({a[31:3], 3'b000}, 1'b0, 2'd3, '0, dummy);   // merged word back
            end
            if (miss && !wr) begin
                for (int w = 0; w < 8; w++)
                    access({a[31:6], 3'(w), 3'b000}, 1'b0, 2'd3, '0, dummy);
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module dcache_top (
    input  logic              clk,
    input  logic              reset,
    // pipeline side
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t wdata,
    input  dcache_pkg::size_t wlen,
    input  logic              wrn,
    input  logic              dcache_enable,
    output dcache_pkg::word_t rdata,
    output logic              dcache_valid,
    output logic              write_done,
    // memory bus side
    output dcache_pkg::addr_t awaddr,
    output logic              awvalid,
    input  logic              awready,
    output dcache_pkg::word_t wdata_m,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready,
    output dcache_pkg::addr_t araddr,
    output logic              arvalid,
    input  logic              arready,
    input  dcache_pkg::word_t rdata_m,
    input  logic              rlast,
    input  logic              rvalid,
    output logic              rready
);
    import dcache_pkg::*;

    logic hit;
    logic victim_dirty;
    logic capture;
    logic beat_start_wb;
    logic beat_start_rf;
    logic beat_step;
    logic fill_start;
    logic fill_write;
    logic fill_done;
    logic mark_dirty;
    logic clean;
    set_idx_t miss_set;
    tag_t miss_tag;
    tag_t victim_tag;
    word_idx_t bus_word;

    assign bready = 1'b1;   // responses always accepted

    dcache_ctrl i_ctrl (
        .clk, .reset, .dcache_enable, .wrn, .hit, .victim_dirty,
        .awready, .wready, .wlast, .bvalid, .arready, .rvalid, .rlast,
        .awvalid, .wvalid, .arvalid, .rready,
        .capture, .beat_start_wb, .beat_start_rf, .beat_step,
        .fill_start, .fill_write, .fill_done, .mark_dirty, .clean,
        .write_done, .dcache_valid
    );

    dcache_tag_store i_tag_store (
        .clk, .reset, .req_addr(addr), .miss_set, .miss_tag,
        .fill_start, .fill_done, .mark_dirty, .clean,
        .hit, .victim_dirty, .victim_tag
    );

    dcache_data_store i_data_store (
        .clk, .req_addr(addr), .wdata, .wlen, .merge(mark_dirty),
        .bus_set(miss_set), .bus_word, .fill_write, .fill_data(rdata_m),
        .rdata, .victim_data(wdata_m)
    );

    dcache_mem_port i_mem_port (
        .clk, .reset, .req_addr(addr), .victim_tag,
        .capture, .beat_start_wb, .beat_start_rf, .beat_step,
        .miss_set, .miss_tag, .bus_word, .awaddr, .araddr, .wlast
    );

endmodule

`default_nettype wire

// ==== dcache_mem_port.sv ====
`default_nettype none
`timescale 1ns/1ns

module dcache_mem_port (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::tag_t      victim_tag,
    input  logic                  capture,
    input  logic                  beat_start_wb,
    input  logic                  beat_start_rf,
    input  logic                  beat_step,
    output dcache_pkg::set_idx_t  miss_set,
    output dcache_pkg::tag_t      miss_tag,
    output dcache_pkg::word_idx_t bus_word,
    output dcache_pkg::addr_t     awaddr,
    output dcache_pkg::addr_t     araddr,
    output logic                  wlast
);
    import dcache_pkg::*;

    addr_t miss_addr;
    word_idx_t beat;

    assign miss_set = miss_addr[BYTE_BITS + WORD_BITS +: SET_BITS];
    assign miss_tag = miss_addr[ADDR_W-1 -: TAG_W];
    assign bus_word = beat;

    // victim line base, then critical word of the miss
    assign awaddr = {victim_tag, miss_set, {(WORD_BITS + BYTE_BITS){1'b0}}};
    assign araddr = {miss_addr[ADDR_W-1:BYTE_BITS], {BYTE_BITS{1'b0}}};
    assign wlast = (beat == word_idx_t'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (capture) begin
            miss_addr <= req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat <= '0;
        end else if (beat_start_wb) begin
            beat <= '0;                                 // write-back goes in order
        end else if (beat_start_rf) begin
            beat <= miss_addr[BYTE_BITS +: WORD_BITS];  // wrap from critical word
        end else if (beat_step) begin
            beat <= beat + 1'b1;                        // modulo line size
        end
    end

endmodule

`default_nettype wire

// ==== dcache_data_store.sv ====
`default_nettype none
`timescale 1ns/1ns

module dcache_data_store (
    input  logic                  clk,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::size_t     wlen,
    input  logic                  merge,
    input  dcache_pkg::set_idx_t  bus_set,
    input  dcache_pkg::word_idx_t bus_word,
    input  logic                  fill_write,
    input  dcache_pkg::word_t     fill_data,
    output dcache_pkg::word_t     rdata,
    output dcache_pkg::word_t     victim_data
);
    import dcache_pkg::*;

    word_t mem [SETS][LINE_WORDS];

    set_idx_t req_set;
    word_idx_t req_word;
    logic [BYTE_BITS-1:0] byte_off;
    logic [DATA_W/8-1:0] size_mask;
    logic [DATA_W/8-1:0] byte_en;
    word_t shifted;
    word_t merged;

    assign req_set = req_addr[BYTE_BITS + WORD_BITS +: SET_BITS];
    assign req_word = req_addr[BYTE_BITS +: WORD_BITS];
    assign byte_off = req_addr[BYTE_BITS-1:0];

    assign rdata = mem[req_set][req_word];
    assign victim_data = mem[bus_set][bus_word];

    always_comb begin
        case (wlen)
            2'd0: size_mask = 8'h01;
            2'd1: size_mask = 8'h03;
            2'd2: size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // new bytes come from the low end of wdata
    assign byte_en = size_mask << byte_off;
    assign shifted = wdata << {byte_off, 3'b000};

    always_comb begin
        merged = rdata;
        for (int b = 0; b < DATA_W/8; b++) begin
            if (byte_en[b]) merged[8*b +: 8] = shifted[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            mem[bus_set][bus_word] <= fill_data;   // refill beat
        end else if (merge) begin
            mem[req_set][req_word] <= merged;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_tag_store.sv ====
`default_nettype none
`timescale 1ns/1ns

module dcache_tag_store (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::addr_t    req_addr,
    input  dcache_pkg::set_idx_t miss_set,
    input  dcache_pkg::tag_t     miss_tag,
    input  logic                fill_start,
    input  logic                fill_done,
    input  logic                mark_dirty,
    input  logic                clean,
    output logic                hit,
    output logic                victim_dirty,
    output dcache_pkg::tag_t     victim_tag
);
    import dcache_pkg::*;

    tag_t tag_mem [SETS];
    logic [SETS-1:0] valid;
    logic [SETS-1:0] dirty;

    set_idx_t req_set;
    tag_t req_tag;

    assign req_set = req_addr[BYTE_BITS + WORD_BITS +: SET_BITS];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];

    assign hit = valid[req_set] && (tag_mem[req_set] == req_tag);
    assign victim_dirty = valid[req_set] && dirty[req_set];
    assign victim_tag = tag_mem[miss_set];  // for the write-back address

    always_ff @(posedge clk) begin
        if (fill_start) begin
            tag_mem[miss_set] <= miss_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (fill_start) valid[miss_set] <= 1'b0;   // line invalid while refilling
            if (fill_done) valid[miss_set] <= 1'b1;
            if (clean) dirty[miss_set] <= 1'b0;
            if (mark_dirty) dirty[req_set] <= 1'b1;    // write hit
        end
    end

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic dcache_enable,
    input  logic wrn,           // 1 write, 0 read
    input  logic hit,
    input  logic victim_dirty,
    input  logic awready,
    input  logic wready,
    input  logic wlast,
    input  logic bvalid,
    input  logic arready,
    input  logic rvalid,
    input  logic rlast,
    output logic awvalid,
    output logic wvalid,
    output logic arvalid,
    output logic rready,
    output logic capture,
    output logic beat_start_wb,
    output logic beat_start_rf,
    output logic beat_step,
    output logic fill_start,
    output logic fill_write,
    output logic fill_done,
    output logic mark_dirty,
    output logic clean,
    output logic write_done,
    output logic dcache_valid
);
    import dcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    logic in_idle;
    logic req_hit;
    logic req_miss;

    assign in_idle = (state == ST_IDLE);
    assign req_hit = in_idle && dcache_enable && hit;
    assign req_miss = in_idle && dcache_enable && !hit;

    // pipeline answers
    assign dcache_valid = req_hit && !wrn;
    assign write_done = req_hit && wrn;
    assign mark_dirty = write_done;         // byte merge at next edge

    assign capture = req_miss;
    assign beat_start_wb = req_miss && victim_dirty;

    // bus handshake side, straight from the state
    assign awvalid = (state == ST_WB_ADDR);
    assign wvalid = (state == ST_WB_DATA);
    assign arvalid = (state == ST_RF_ADDR);
    assign rready = (state == ST_RF_DATA);

    assign beat_step = (wvalid && wready) || (rready && rvalid);
    assign clean = wvalid && wready && wlast;      // victim fully written out
    assign fill_start = arvalid && arready;        // new tag, line invalid
    assign beat_start_rf = fill_start;             // counter to critical word
    assign fill_write = rready && rvalid;
    assign fill_done = fill_write && rlast;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req_miss) begin
                    state_next = victim_dirty ? ST_WB_ADDR : ST_RF_ADDR;
                end
            end
            ST_WB_ADDR: begin
                if (awready) begin
                    state_next = ST_WB_DATA;
                end
            end
            ST_WB_DATA: begin
                if (wready && wlast) begin
                    state_next = ST_WB_RESP;
                end
            end
            ST_WB_RESP: begin
                if (bvalid) begin
                    state_next = ST_RF_ADDR;   // response code not checked
                end
            end
            ST_RF_ADDR: begin
                if (arready) begin
                    state_next = ST_RF_DATA;
                end
            end
            ST_RF_DATA: begin
                if (rvalid && rlast) begin
                    state_next = ST_IDLE;      // request replays as a hit
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int BYTE_BITS = 3;   // byte within a word
    localparam int WORD_BITS = 3;   // word within a line
    localparam int SET_BITS = 4;    // set index
    localparam int TAG_W = ADDR_W - SET_BITS - WORD_BITS - BYTE_BITS;
    localparam int LINE_WORDS = 1 << WORD_BITS;
    localparam int SETS = 1 << SET_BITS;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [WORD_BITS-1:0] word_idx_t;

    // access is 2**size bytes
    typedef logic [1:0] size_t;

    // miss handling sequence
    // a dirty miss walks through the write-back states before the refill
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,  // hits served here
        ST_WB_ADDR = 3'd1,  // victim address on aw
        ST_WB_DATA = 3'd2,  // victim beats on w
        ST_WB_RESP = 3'd3,  // wait for b
        ST_RF_ADDR = 3'd4,  // refill address on ar
        ST_RF_DATA = 3'd5   // refill beats on r
    } ctrl_state_t;

endpackage

`default_nettype wire
